// ==== tb.f ====
logic/bch_pkg.sv
logic/bch_ctrl.sv
logic/gf_poly_divider.sv
logic/euclid_poly_update.sv
logic/key_equation_solver.sv
logic/chien_search.sv
logic/bch_decoder.sv
sim/bch_decoder_props.sv
sim/bch_decoder_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bch_decoder_tb -f tb.f \
    && ./obj_dir/Vbch_decoder_tb > sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// ==== sim/bch_decoder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bch_decoder_tb;
    import bch_pkg::*;

    localparam int reset_cycles = 8;
    localparam int num_table    = 26;
    localparam int num_random   = 40;
    localparam int max_cycles   = 80 * (num_table + num_random) + reset_cycles;

    // Error count followed by three locations with F in unused slots
    localparam logic [15:0] block_table [num_table] = '{
        16'h1_0_F_F, 16'h1_1_F_F, 16'h1_2_F_F, 16'h1_3_F_F, 16'h1_4_F_F,
        16'h1_5_F_F, 16'h1_6_F_F, 16'h1_7_F_F, 16'h1_8_F_F, 16'h1_9_F_F,
        16'h1_A_F_F, 16'h1_B_F_F, 16'h1_C_F_F, 16'h1_D_F_F, 16'h1_E_F_F,
        16'h2_0_E_F, 16'h2_E_0_F, 16'h2_3_7_F, 16'h2_9_2_F, 16'h2_1_D_F,
        16'h3_0_1_2, 16'h3_2_1_0, 16'h3_C_D_E, 16'h3_0_7_E, 16'h3_5_3_4,
        16'h3_6_B_1
    };

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    gf_exp_t    in_syndrome;
    logic       out_valid;
    loc_t       out_location;

    logic [3:0] pow_tab [15];
    int         log_tab [16];
    int         cur_count;
    int         cur_locs [3];
    loc_t       expect_q [$];
    int         blocks_sent = 0;
    int         beats_seen  = 0;
    int         cycle_count = 0;
    integer     seed;

    bch_decoder uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_syndrome  (in_syndrome),
        .out_valid    (out_valid),
        .out_location (out_location)
    );

    always #50 clk = ~clk;

    // ============================================================
    // Reference model
    // ============================================================
    function automatic void build_field_tables();
        logic [3:0] v;
        v = 4'b0001;
        for (int i = 0; i < 16; i++) begin
            log_tab[i] = 15;
        end
        for (int i = 0; i < 15; i++) begin
            pow_tab[i] = v;
            log_tab[v] = i;
            // Multiply by alpha and fold x^4 back as x + 1
            v = {v[2:0], 1'b0} ^ (v[3] ? 4'b0011 : 4'b0000);
        end
    endfunction

    // S_j as a sum of alpha^(j*loc) over all error locations
    function automatic gf_exp_t syndrome_exp(input int j);
        logic [3:0] acc;
        acc = 4'b0000;
        for (int e = 0; e < cur_count; e++) begin
            acc = acc ^ pow_tab[(j * cur_locs[e]) % 15];
        end
        return gf_exp_t'(log_tab[acc]);
    endfunction

    task automatic push_expected();
        int sorted [3];
        int tmp;
        for (int i = 0; i < 3; i++) begin
            sorted[i] = (i < cur_count) ? cur_locs[i] : 15;
        end
        // Padding value 15 sorts to the end
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 2; i++) begin
                if (sorted[i] > sorted[i+1]) begin
                    tmp         = sorted[i];
                    sorted[i]   = sorted[i+1];
                    sorted[i+1] = tmp;
                end
            end
        end
        for (int i = 0; i < 3; i++) begin
            expect_q.push_back(loc_t'(sorted[i]));
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic load_table_block(input int idx);
        cur_count   = int'(block_table[idx][15:12]);
        cur_locs[0] = int'(block_table[idx][11:8]);
        cur_locs[1] = int'(block_table[idx][7:4]);
        cur_locs[2] = int'(block_table[idx][3:0]);
    endtask

    task automatic make_random_block();
        int   cand;
        logic dup;
        cur_count = 1 + int'($unsigned($random(seed)) % 3);
        for (int i = 0; i < 3; i++) begin
            cur_locs[i] = 15;
        end
        for (int i = 0; i < cur_count; i++) begin
            dup  = 1'b1;
            cand = 0;
            while (dup) begin
                cand = int'($unsigned($random(seed)) % 15);
                dup  = 1'b0;
                for (int k = 0; k < i; k++) begin
                    if (cur_locs[k] == cand) begin
                        dup = 1'b1;
                    end
                end
            end
            cur_locs[i] = cand;
        end
    endtask

    // Six syndromes back to back from a rising edge
    task automatic send_block();
        push_expected();
        blocks_sent++;
        for (int j = 1; j <= 6; j++) begin
            in_valid    <= 1'b1;
            in_syndrome <= syndrome_exp(j);
            @(posedge clk);
        end
        in_valid    <= 1'b0;
        in_syndrome <= '0;
    endtask

    task automatic wait_for_output();
        while (beats_seen < 3 * blocks_sent) begin
            @(posedge clk);
        end
    endtask

    // ============================================================
    // Output checks at the falling edge
    // ============================================================
    always @(negedge clk) begin : check_outputs
        loc_t expected;
        assert (!out_valid || expect_q.size() != 0) else begin
            stop_on_error($sformatf(
                "MISMATCH at %0t ns: out_valid high with no block pending", $time));
        end
        if (out_valid && expect_q.size() != 0) begin
            expected = expect_q.pop_front();
            assert (out_location == expected) else begin
                stop_on_error($sformatf(
                    "MISMATCH at %0t ns: beat %0d gave location %0d, expected %0d",
                    $time, beats_seen, out_location, expected));
            end
            beats_seen++;
        end else if (!out_valid) begin
            assert (out_location == '0) else begin
                stop_on_error($sformatf(
                    "MISMATCH at %0t ns: out_location is %0d while out_valid is low",
                    $time, out_location));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles, the decoder stopped producing output",
                     cycle_count);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_syndrome = '0;
        seed        = 32'h9e12;
        build_field_tables();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        // Idle gap before the first block
        repeat (2) @(posedge clk);

        for (int b = 0; b < num_table; b++) begin
            load_table_block(b);
            send_block();
            wait_for_output();
        end

        // Next block follows the last beat of the previous one
        for (int b = 0; b < num_random; b++) begin
            make_random_block();
            send_block();
            wait_for_output();
        end

        // A few quiet cycles to catch any stray beat
        repeat (4) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/bch_decoder_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module bch_decoder_props (
    input logic          clk,
    input logic          rst_n,
    input logic          in_valid,
    input logic          div_en,
    input logic          update_en,
    input logic          search_en,
    input logic          out_en,
    input logic          out_valid,
    input bch_pkg::loc_t out_location
);

    // ============================================================
    // Output framing
    // ============================================================

    // Three beats per block, then the line drops again
    property p_three_beats;
        @(posedge clk) disable iff (!rst_n)
            $rose(out_valid) |-> out_valid ##1 out_valid ##1 out_valid ##1 !out_valid;
    endproperty

    a_three_beats: assert property (p_three_beats)
        else $error("out_valid burst did not last exactly three cycles");

    // Location is zero between beats
    property p_location_idle;
        @(posedge clk) disable iff (!rst_n)
            !out_valid |-> (out_location == '0);
    endproperty

    a_location_idle: assert property (p_location_idle)
        else $error("out_location nonzero while out_valid is low");

    // ============================================================
    // Input protocol
    // ============================================================

    // Any active strobe means the FSM is past idle and load
    property p_input_window;
        @(posedge clk) disable iff (!rst_n)
            in_valid |-> !(div_en || update_en || search_en || out_en);
    endproperty

    a_input_window: assert property (p_input_window)
        else $error("in_valid high while the decoder is busy");

endmodule

bind bch_decoder bch_decoder_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .div_en       (div_en),
    .update_en    (update_en),
    .search_en    (search_en),
    .out_en       (out_en),
    .out_valid    (out_valid),
    .out_location (out_location)
);

`default_nettype wire

// ==== logic/bch_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bch_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  bch_pkg::gf_exp_t in_syndrome,
    output logic             out_valid,
    output bch_pkg::loc_t    out_location
);
    import bch_pkg::*;

    logic  div_en;
    logic  update_en;
    logic  search_en;
    logic  out_en;
    logic  clear;
    logic  solve_done;
    logic  search_done;
    logic  out_done;
    poly_t sigma;

    bch_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .solve_done  (solve_done),
        .search_done (search_done),
        .out_done    (out_done),
        .div_en      (div_en),
        .update_en   (update_en),
        .search_en   (search_en),
        .out_en      (out_en),
        .clear       (clear)
    );

    key_equation_solver u_solver (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_syndrome (in_syndrome),
        .div_en      (div_en),
        .update_en   (update_en),
        .clear       (clear),
        .solve_done  (solve_done),
        .sigma       (sigma)
    );

    chien_search u_search (
        .clk          (clk),
        .rst_n        (rst_n),
        .sigma        (sigma),
        .search_en    (search_en),
        .out_en       (out_en),
        .clear        (clear),
        .search_done  (search_done),
        .out_done     (out_done),
        .out_valid    (out_valid),
        .out_location (out_location)
    );

endmodule

`default_nettype wire

// ==== logic/chien_search.sv ====
`timescale 1ns/1ps
`default_nettype none

module chien_search (
    input  logic           clk,
    input  logic           rst_n,
    input  bch_pkg::poly_t sigma,
    input  logic           search_en,
    input  logic           out_en,
    input  logic           clear,
    output logic           search_done,
    output logic           out_done,
    output logic           out_valid,
    output bch_pkg::loc_t  out_location
);
    import bch_pkg::*;

    loc_t                pos;
    logic [1:0]          root_cnt;
    logic [1:0]          beat_cnt;
    loc_t                slots [t_max];
    logic [gf_width-1:0] eval_sum;
    logic                is_root;

    // Exponent of alpha^(-i*p)
    function automatic gf_exp_t term_exp(input int i, input loc_t p);
        int r;
        r = (i * int'(p)) % field_order;
        if (r == 0) begin
            return '0;
        end
        return gf_exp_t'(field_order - r);
    endfunction

    // ============================================================
    // Evaluate sigma at alpha^(-pos)
    // ============================================================
    always_comb begin
        eval_sum = '0;
        // Solver guarantees deg sigma <= 3
        for (int i = 0; i <= t_max; i++) begin
            eval_sum = eval_sum ^ exp_to_vec(gf_mul(sigma[i], term_exp(i, pos)));
        end
    end

    assign is_root = (eval_sum == '0);

    // Third root or last position ends the search
    assign search_done = search_en &&
                         ((is_root && root_cnt == 2'(t_max - 1)) || pos == loc_t'(field_order - 1));
    assign out_done    = out_en && (beat_cnt == 2'(t_max - 1));

    // ============================================================
    // Position counter and location slots
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos      <= '0;
            root_cnt <= '0;
            beat_cnt <= '0;
            for (int i = 0; i < t_max; i++) begin
                slots[i] <= zero_exp;
            end
        end else if (clear) begin
            pos      <= '0;
            root_cnt <= '0;
            beat_cnt <= '0;
            for (int i = 0; i < t_max; i++) begin
                slots[i] <= zero_exp;
            end
        end else begin
            if (search_en) begin
                pos <= pos + 1'b1;
                if (is_root) begin
                    slots[root_cnt] <= pos;
                    root_cnt        <= root_cnt + 1'b1;
                end
            end
            if (out_en) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Output beats, zero between blocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            out_location <= '0;
        end else begin
            out_valid    <= out_en;
            out_location <= out_en ? slots[beat_cnt] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/key_equation_solver.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_equation_solver (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  bch_pkg::gf_exp_t in_syndrome,
    input  logic             div_en,
    input  logic             update_en,
    input  logic             clear,
    output logic             solve_done,
    output bch_pkg::poly_t   sigma
);
    import bch_pkg::*;

    poly_t omega_prev;
    poly_t omega_cur;
    poly_t sigma_prev;
    poly_t sigma_cur;
    poly_t quotient_d;
    poly_t quotient_q;
    poly_t omega_next;
    poly_t sigma_next;
    logic  omega_low;
    logic  sigma_low;

    // Polynomial with a single unit coefficient
    function automatic poly_t monomial(input int deg);
        poly_t p;
        p      = {poly_len{zero_exp}};
        p[deg] = '0;
        return p;
    endfunction

    // ============================================================
    // Omega and sigma registers
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            omega_prev <= monomial(num_synd);
            omega_cur  <= {poly_len{zero_exp}};
            sigma_prev <= {poly_len{zero_exp}};
            sigma_cur  <= monomial(0);
        end else if (clear) begin
            omega_prev <= monomial(num_synd);
            omega_cur  <= {poly_len{zero_exp}};
            sigma_prev <= {poly_len{zero_exp}};
            sigma_cur  <= monomial(0);
        end else if (in_valid) begin
            // New syndrome enters at slot 5, S1 settles in slot 0
            omega_cur <= {zero_exp, in_syndrome, omega_cur[poly_len-2:1]};
        end else if (update_en) begin
            omega_prev <= omega_cur;
            omega_cur  <= omega_next;
            sigma_prev <= sigma_cur;
            sigma_cur  <= sigma_next;
        end
    end

    // ============================================================
    // Euclid step
    // ============================================================
    gf_poly_divider u_divider (
        .dividend (omega_prev),
        .divisor  (omega_cur),
        .quotient (quotient_d)
    );

    always_ff @(posedge clk) begin
        if (div_en) begin
            quotient_q <= quotient_d;
        end
    end

    // Remainder of the division
    euclid_poly_update u_omega_update (
        .prev_poly (omega_prev),
        .cur_poly  (omega_cur),
        .quotient  (quotient_q),
        .next_poly (omega_next)
    );

    euclid_poly_update u_sigma_update (
        .prev_poly (sigma_prev),
        .cur_poly  (sigma_cur),
        .quotient  (quotient_q),
        .next_poly (sigma_next)
    );

    // Stop when deg omega < 3 and deg sigma <= 3
    always_comb begin
        omega_low = 1'b1;
        sigma_low = 1'b1;
        for (int i = t_max; i < poly_len; i++) begin
            if (omega_next[i] != zero_exp) begin
                omega_low = 1'b0;
            end
        end
        for (int i = t_max + 1; i < poly_len; i++) begin
            if (sigma_next[i] != zero_exp) begin
                sigma_low = 1'b0;
            end
        end
    end

    assign solve_done = update_en && omega_low && sigma_low;
    assign sigma      = sigma_cur;

endmodule

`default_nettype wire

// ==== logic/euclid_poly_update.sv ====
`timescale 1ns/1ps
`default_nettype none

module euclid_poly_update (
    input  bch_pkg::poly_t prev_poly,
    input  bch_pkg::poly_t cur_poly,
    input  bch_pkg::poly_t quotient,
    output bch_pkg::poly_t next_poly
);
    import bch_pkg::*;

    // Running sums in bit-vector form
    logic [gf_width-1:0] acc [poly_len];

    always_comb begin
        for (int k = 0; k < poly_len; k++) begin
            acc[k] = exp_to_vec(prev_poly[k]);
        end
        // Product terms above degree 6 are dropped
        for (int a = 0; a < poly_len; a++) begin
            for (int b = 0; b < poly_len; b++) begin
                if (a + b < poly_len) begin
                    acc[a+b] = acc[a+b] ^ exp_to_vec(gf_mul(quotient[a], cur_poly[b]));
                end
            end
        end
        for (int k = 0; k < poly_len; k++) begin
            next_poly[k] = vec_to_exp(acc[k]);
        end
    end

endmodule

`default_nettype wire

// ==== logic/gf_poly_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module gf_poly_divider (
    input  bch_pkg::poly_t dividend,
    input  bch_pkg::poly_t divisor,
    output bch_pkg::poly_t quotient
);
    import bch_pkg::*;

    int                  div_deg;
    logic                div_nonzero;
    gf_exp_t             lead_inv;
    logic [gf_width-1:0] rem [poly_len];
    gf_exp_t             q_coef;
    int                  shift;

    // ============================================================
    // Leading term of the divisor and its inverse
    // ============================================================
    always_comb begin
        div_deg     = 0;
        div_nonzero = 1'b0;
        for (int i = 0; i < poly_len; i++) begin
            if (divisor[i] != zero_exp) begin
                div_deg     = i;
                div_nonzero = 1'b1;
            end
        end
        // alpha^0 is its own inverse
        if (divisor[div_deg] == '0) begin
            lead_inv = '0;
        end else begin
            lead_inv = gf_exp_t'(field_order - int'(divisor[div_deg]));
        end
    end

    // ============================================================
    // Long division, highest remainder degree first
    // ============================================================
    always_comb begin
        q_coef   = zero_exp;
        shift    = 0;
        quotient = {poly_len{zero_exp}};
        for (int k = 0; k < poly_len; k++) begin
            rem[k] = exp_to_vec(dividend[k]);
        end
        for (int i = poly_len - 1; i >= 0; i--) begin
            if (div_nonzero && i >= div_deg) begin
                shift           = i - div_deg;
                q_coef          = gf_mul(vec_to_exp(rem[i]), lead_inv);
                quotient[shift] = q_coef;
                // Cancel the top term of the remainder
                for (int k = 0; k < poly_len; k++) begin
                    if (k >= shift) begin
                        rem[k] = rem[k] ^ exp_to_vec(gf_mul(q_coef, divisor[k - shift]));
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/bch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bch_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic solve_done,
    input  logic search_done,
    input  logic out_done,
    output logic div_en,
    output logic update_en,
    output logic search_en,
    output logic out_en,
    output logic clear
);
    import bch_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (in_valid) begin
                    state_next = s_load;
                end
            end
            // Syndromes keep arriving until in_valid drops
            s_load: begin
                if (!in_valid) begin
                    state_next = s_divide;
                end
            end
            s_divide: state_next = s_update;
            s_update: begin
                state_next = solve_done ? s_search : s_divide;
            end
            s_search: begin
                if (search_done) begin
                    state_next = s_output;
                end
            end
            s_output: begin
                if (out_done) begin
                    state_next = s_idle;
                end
            end
            default: state_next = s_idle;
        endcase
    end

    // Strobes decoded from the state
    assign div_en    = (state == s_divide);
    assign update_en = (state == s_update);
    assign search_en = (state == s_search);
    assign out_en    = (state == s_output);
    assign clear     = out_en && out_done;

endmodule

`default_nettype wire

// ==== logic/bch_pkg.sv ====
`default_nettype none

package bch_pkg;

    // ============================================================
    // Field and code constants
    // ============================================================
    localparam int gf_width    = 4;
    localparam int field_order = 15;
    localparam int t_max       = 3;
    localparam int num_synd    = 6;
    localparam int poly_len    = 7;

    // Symbols travel in exponent form
    typedef logic [gf_width-1:0] gf_exp_t;

    // Exponent code for the field zero
    localparam gf_exp_t zero_exp = gf_exp_t'(15);

    // Coefficient 0 sits in slot 0
    typedef gf_exp_t [poly_len-1:0] poly_t;

    typedef logic [gf_width-1:0] loc_t;

    typedef enum logic [2:0] {
        s_idle,
        s_load,
        s_divide,
        s_update,
        s_search,
        s_output
    } ctrl_state_t;

    // ============================================================
    // GF(16) arithmetic over x^4 + x + 1
    // ============================================================
    function automatic logic [gf_width-1:0] exp_to_vec(input gf_exp_t e);
        logic [gf_width-1:0] v;
        v = '0;
        if (e != zero_exp) begin
            v = 4'b0001;
            // Repeated multiply by x, folding x^4 back as x + 1
            for (int i = 0; i < field_order - 1; i++) begin
                if (i < e) begin
                    v = {v[gf_width-2:0], 1'b0} ^ (v[gf_width-1] ? 4'b0011 : 4'b0000);
                end
            end
        end
        return v;
    endfunction

    function automatic gf_exp_t vec_to_exp(input logic [gf_width-1:0] v);
        gf_exp_t e;
        e = zero_exp;
        for (int i = 0; i < field_order; i++) begin
            if (exp_to_vec(gf_exp_t'(i)) == v) begin
                e = gf_exp_t'(i);
            end
        end
        return e;
    endfunction

    // Exponents add modulo 15
    function automatic gf_exp_t gf_mul(input gf_exp_t a, input gf_exp_t b);
        logic [gf_width:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (a == zero_exp || b == zero_exp) begin
            return zero_exp;
        end
        if (sum >= field_order) begin
            sum = sum - (gf_width + 1)'(field_order);
        end
        return sum[gf_width-1:0];
    endfunction

endpackage

`default_nettype wire
